// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - riscv_pkg.sv
  - dmem_if.sv
  - reg_file.sv
  - imm_gen.sv
  - alu.sv
  - decoder.sv
  - mem_align.sv
  - imem.sv
  - dmem.sv
  - cpu.sv
  - target: test
    files:
      - tb_cpu.sv

// ==== alu.sv ====
`timescale 1ns/100ps

module alu (
    input riscv_pkg::word_t a,
    input riscv_pkg::word_t b,
    input riscv_pkg::alu_op_e op,
    input logic [2:0] funct3,
    output riscv_pkg::word_t result,
    output logic br_taken
);
    always_comb begin
        case (op)
            riscv_pkg::alu_sub:    result = a - b;
            riscv_pkg::alu_sll:    result = a << b[4:0];
            riscv_pkg::alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            riscv_pkg::alu_sltu:   result = {31'b0, a < b};
            riscv_pkg::alu_xor:    result = a ^ b;
            riscv_pkg::alu_srl:    result = a >> b[4:0];
            riscv_pkg::alu_sra:    result = $signed(a) >>> b[4:0];
            riscv_pkg::alu_or:     result = a | b;
            riscv_pkg::alu_and:    result = a & b;
            riscv_pkg::alu_pass_b: result = b;
            default:               result = a + b;
        endcase
    end

    // Branch compare on the same operands
    always_comb begin
        case (funct3)
            3'b000:  br_taken = (a == b);
            3'b001:  br_taken = (a != b);
            3'b100:  br_taken = $signed(a) < $signed(b);
            3'b101:  br_taken = $signed(a) >= $signed(b);
            3'b110:  br_taken = a < b;
            3'b111:  br_taken = a >= b;
            default: br_taken = 1'b0;
        endcase
    end

endmodule

// ==== cpu.sv ====
`timescale 1ns/100ps

module cpu #(
    parameter riscv_pkg::word_t RESET_PC = '0,
    parameter int MEM_WORDS = 1024
) (
    input logic clk,
    input logic rst,
    input logic prog_we,
    input riscv_pkg::word_t prog_addr,
    input riscv_pkg::word_t prog_data,
    output riscv_pkg::word_t tohost,
    output logic tohost_valid
);
    localparam int AW = $clog2(MEM_WORDS);

    riscv_pkg::word_t pc_fd, next_pc, imem_rdata, inst_fd, imm_fd, rd1, rd2;
    riscv_pkg::ctrl_t ctrl_fd;
    riscv_pkg::imm_fmt_e fmt_fd;

    riscv_pkg::word_t pc_xm, imm_xm, rs1_val_xm, rs2_val_xm;
    riscv_pkg::word_t a_xm, b_xm, alu_a, alu_b, alu_result, target;
    riscv_pkg::ctrl_t ctrl_xm;
    logic br_taken, redirect, fwd_a, fwd_b;

    riscv_pkg::word_t pc_w, alu_w, load_data, wb_data;
    riscv_pkg::ctrl_t ctrl_w;

    dmem_if dmem_bus ();

    // Fetch address is next_pc so imem data lines up with pc_fd
    assign next_pc = rst ? RESET_PC : redirect ? target : pc_fd + 32'd4;

    always_ff @(posedge clk) begin
        pc_fd <= next_pc;
    end

    imem #(.MEM_WORDS(MEM_WORDS)) u_imem (
        .clk(clk),
        .we(prog_we),
        .waddr(prog_addr[AW-1:0]),
        .wdata(prog_data),
        .raddr(next_pc[AW+1:2]),
        .rdata(imem_rdata)
    );

    // Wrong-path instruction behind a taken redirect
    assign inst_fd = redirect ? riscv_pkg::nop_inst : imem_rdata;

    decoder u_decoder (.inst(inst_fd), .ctrl(ctrl_fd), .fmt(fmt_fd));

    imm_gen u_imm_gen (.inst(inst_fd), .fmt(fmt_fd), .imm(imm_fd));

    reg_file u_reg_file (
        .clk(clk),
        .we(ctrl_w.reg_write),
        .ra1(ctrl_fd.rs1),
        .ra2(ctrl_fd.rs2),
        .wa(ctrl_w.rd),
        .wd(wb_data),
        .rd1(rd1),
        .rd2(rd2)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_xm <= '0;
        end else begin
            ctrl_xm <= ctrl_fd;
        end
        pc_xm <= pc_fd;
        imm_xm <= imm_fd;
        rs1_val_xm <= rd1;
        rs2_val_xm <= rd2;
    end

    assign fwd_a = ctrl_w.reg_write && ctrl_w.rd != 5'd0 && ctrl_w.rd == ctrl_xm.rs1;
    assign fwd_b = ctrl_w.reg_write && ctrl_w.rd != 5'd0 && ctrl_w.rd == ctrl_xm.rs2;
    assign a_xm = fwd_a ? wb_data : rs1_val_xm;
    assign b_xm = fwd_b ? wb_data : rs2_val_xm;

    assign alu_a = ctrl_xm.a_is_pc ? pc_xm : a_xm;
    assign alu_b = ctrl_xm.b_is_imm ? imm_xm : b_xm;

    alu u_alu (
        .a(alu_a),
        .b(alu_b),
        .op(ctrl_xm.alu_op),
        .funct3(ctrl_xm.funct3),
        .result(alu_result),
        .br_taken(br_taken)
    );

    assign redirect = ctrl_xm.is_jal || ctrl_xm.is_jalr || (ctrl_xm.is_branch && br_taken);
    assign target = ctrl_xm.is_jalr ? {alu_result[31:1], 1'b0} : pc_xm + imm_xm;

    mem_align u_mem_align (
        .clk(clk),
        .rst(rst),
        .addr_xm(alu_result),
        .store_data(b_xm),
        .funct3_xm(ctrl_xm.funct3),
        .mem_write(ctrl_xm.mem_write),
        .mem_read_w(ctrl_w.mem_read),
        .load_data(load_data),
        .bus(dmem_bus.master)
    );

    dmem #(.MEM_WORDS(MEM_WORDS)) u_dmem (.clk(clk), .bus(dmem_bus.slave));

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_w <= '0;
        end else begin
            ctrl_w <= ctrl_xm;
        end
        pc_w <= pc_xm;
        alu_w <= alu_result;
    end

    always_comb begin
        case (ctrl_w.wb_sel)
            riscv_pkg::wb_mem:      wb_data = load_data;
            riscv_pkg::wb_pc_plus4: wb_data = pc_w + 32'd4;
            default:                wb_data = alu_w;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tohost <= '0;
            tohost_valid <= 1'b0;
        end else begin
            tohost_valid <= ctrl_w.csr_write;
            if (ctrl_w.csr_write) begin
                tohost <= alu_w;
            end
        end
    end

    // tohost keeps its value until the next csrw
    tohost_holds: assert property (@(posedge clk) disable iff (rst)
        !ctrl_w.csr_write |=> $stable(tohost));

endmodule

// ==== decoder.sv ====
`timescale 1ns/100ps

module decoder (
    input riscv_pkg::word_t inst,
    output riscv_pkg::ctrl_t ctrl,
    output riscv_pkg::imm_fmt_e fmt
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    function automatic riscv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? riscv_pkg::alu_sub : riscv_pkg::alu_add;
            3'b001:  return riscv_pkg::alu_sll;
            3'b010:  return riscv_pkg::alu_slt;
            3'b011:  return riscv_pkg::alu_sltu;
            3'b100:  return riscv_pkg::alu_xor;
            3'b101:  return alt ? riscv_pkg::alu_sra : riscv_pkg::alu_srl;
            3'b110:  return riscv_pkg::alu_or;
            default: return riscv_pkg::alu_and;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctrl = '0;
        ctrl.rd = inst[11:7];
        ctrl.rs1 = inst[19:15];
        ctrl.rs2 = inst[24:20];
        ctrl.funct3 = funct3;
        fmt = riscv_pkg::imm_i;
        case (opcode)
            riscv_pkg::op_reg: begin
                ctrl.alu_op = arith_op(funct3, funct7[5]);
                ctrl.reg_write = 1'b1;
            end
            riscv_pkg::op_imm: begin
                // Only srai uses bit 30, addi has no subtract form
                ctrl.alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            riscv_pkg::op_lui, riscv_pkg::op_auipc: begin
                ctrl.alu_op = (opcode == riscv_pkg::op_lui) ? riscv_pkg::alu_pass_b
                                                             : riscv_pkg::alu_add;
                ctrl.a_is_pc = (opcode == riscv_pkg::op_auipc);
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                fmt = riscv_pkg::imm_u;
            end
            riscv_pkg::op_load: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel = riscv_pkg::wb_mem;
            end
            riscv_pkg::op_store: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.mem_write = 1'b1;
                fmt = riscv_pkg::imm_s;
            end
            riscv_pkg::op_branch: begin
                ctrl.is_branch = 1'b1;
                fmt = riscv_pkg::imm_b;
            end
            riscv_pkg::op_jal, riscv_pkg::op_jalr: begin
                ctrl.is_jal = (opcode == riscv_pkg::op_jal);
                ctrl.is_jalr = (opcode == riscv_pkg::op_jalr);
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel = riscv_pkg::wb_pc_plus4;
                fmt = ctrl.is_jal ? riscv_pkg::imm_j : riscv_pkg::imm_i;
            end
            riscv_pkg::op_system: begin
                // csrw tohost, rs1 passes through the ALU as rs1 + x0
                if (funct3 == 3'b001 && inst[31:20] == riscv_pkg::csr_tohost) begin
                    ctrl.rs2 = 5'd0;
                    ctrl.csr_write = 1'b1;
                end else begin
                    ctrl = '0;
                end
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== dmem.sv ====
`timescale 1ns/100ps

module dmem #(
    parameter int MEM_WORDS = 1024
) (
    input logic clk,
    dmem_if.slave bus
);
    localparam int AW = $clog2(MEM_WORDS);

    riscv_pkg::word_t mem [MEM_WORDS];
    logic [AW-1:0] idx;

    assign idx = bus.addr[AW+1:2];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (bus.be[i]) begin
                mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
        // Old word on a same-cycle write
        bus.rdata <= mem[idx];
    end

endmodule

// ==== dmem_if.sv ====
`timescale 1ns/100ps

interface dmem_if;
    riscv_pkg::word_t addr;
    riscv_pkg::word_t wdata;
    logic [3:0] be;
    riscv_pkg::word_t rdata;

    modport master (
        output addr, wdata, be,
        input rdata
    );

    modport slave (
        input addr, wdata, be,
        output rdata
    );
endinterface

// ==== imem.sv ====
`timescale 1ns/100ps

module imem #(
    parameter int MEM_WORDS = 1024
) (
    input logic clk,
    input logic we,
    input logic [$clog2(MEM_WORDS)-1:0] waddr,
    input riscv_pkg::word_t wdata,
    input logic [$clog2(MEM_WORDS)-1:0] raddr,
    output riscv_pkg::word_t rdata
);
    riscv_pkg::word_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen (
    input riscv_pkg::word_t inst,
    input riscv_pkg::imm_fmt_e fmt,
    output riscv_pkg::word_t imm
);
    always_comb begin
        case (fmt)
            riscv_pkg::imm_s: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            riscv_pkg::imm_b: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            riscv_pkg::imm_u: begin
                imm = {inst[31:12], 12'b0};
            end
            riscv_pkg::imm_j: begin
                // Scrambled J layout, bit 0 implied
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
        endcase
    end

endmodule

// ==== mem_align.sv ====
`timescale 1ns/100ps

module mem_align (
    input logic clk,
    input logic rst,
    input riscv_pkg::word_t addr_xm,
    input riscv_pkg::word_t store_data,
    input logic [2:0] funct3_xm,
    input logic mem_write,
    input logic mem_read_w,
    output riscv_pkg::word_t load_data,
    dmem_if.master bus
);
    logic [1:0] off_w;
    logic [2:0] funct3_w;
    riscv_pkg::word_t lane;

    always_comb begin
        bus.addr = addr_xm;
        bus.wdata = store_data << {addr_xm[1:0], 3'b000};
        bus.be = 4'b0000;
        if (mem_write) begin
            case (funct3_xm[1:0])
                2'b00:   bus.be = 4'b0001 << addr_xm[1:0];
                2'b01:   bus.be = 4'b0011 << addr_xm[1:0];
                default: bus.be = 4'b1111;
            endcase
        end
    end

    // Offset and width follow the access into W, where rdata arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            off_w <= 2'b00;
            funct3_w <= 3'b000;
        end else begin
            off_w <= addr_xm[1:0];
            funct3_w <= funct3_xm;
        end
    end

    assign lane = bus.rdata >> {off_w, 3'b000};

    always_comb begin
        case (funct3_w)
            3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};
            3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};
            3'b100:  load_data = {24'b0, lane[7:0]};
            3'b101:  load_data = {16'b0, lane[15:0]};
            default: load_data = lane;
        endcase
    end

    store_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_write |-> !((funct3_xm[1:0] == 2'b01 && addr_xm[0]) ||
                        (funct3_xm[1:0] == 2'b10 && addr_xm[1:0] != 2'b00)));
    load_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_read_w |-> !((funct3_w[1:0] == 2'b01 && off_w[0]) ||
                         (funct3_w[1:0] == 2'b10 && off_w != 2'b00)));

endmodule

// ==== reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input logic clk,
    input logic we,
    input riscv_pkg::reg_addr_t ra1,
    input riscv_pkg::reg_addr_t ra2,
    input riscv_pkg::reg_addr_t wa,
    input riscv_pkg::word_t wd,
    output riscv_pkg::word_t rd1,
    output riscv_pkg::word_t rd2
);
    riscv_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so FD sees the value retiring in W
    assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

    // A write to a nonzero register is held for later reads
    write_lands: assert property (@(posedge clk)
        (we && wa != 5'd0) |=> regs[$past(wa)] == $past(wd));

endmodule

// ==== riscv_pkg.sv ====
package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // Major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    // addi x0, x0, 0
    localparam word_t nop_inst = 32'h0000_0013;
    localparam logic [11:0] csr_tohost = 12'h51e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_fmt_e;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc_plus4} wb_sel_e;

    typedef struct packed {
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic [2:0] funct3;
        alu_op_e alu_op;
        logic a_is_pc;
        logic b_is_imm;
        logic is_branch;
        logic is_jal;
        logic is_jalr;
        logic mem_read;
        logic mem_write;
        logic reg_write;
        wb_sel_e wb_sel;
        logic csr_write;
    } ctrl_t;

endpackage

// ==== tb_cpu.sv ====
`timescale 1ns/100ps

module tb_cpu;
    logic clk;
    logic rst;
    logic prog_we;
    riscv_pkg::word_t prog_addr;
    riscv_pkg::word_t prog_data;
    riscv_pkg::word_t tohost;
    logic tohost_valid;

    riscv_pkg::word_t prog[$];
    riscv_pkg::word_t expv[$];
    riscv_pkg::word_t got[$];
    riscv_pkg::word_t rng = 32'hfd7728dd;
    logic [7:0] dmodel [12];
    int test_errors;
    int total_errors = 0;
    int failed_tests = 0;

    cpu #(.RESET_PC(32'h0), .MEM_WORDS(256)) UUT (
        .clk(clk),
        .rst(rst),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .tohost(tohost),
        .tohost_valid(tohost_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic riscv_pkg::word_t xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic riscv_pkg::word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic riscv_pkg::word_t enc_r(logic [6:0] f7, logic [2:0] f3,
                                               riscv_pkg::reg_addr_t rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, riscv_pkg::op_reg};
    endfunction

    function automatic riscv_pkg::word_t enc_i(logic [6:0] op, logic [2:0] f3,
                                               riscv_pkg::reg_addr_t rd, rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic riscv_pkg::word_t enc_s(logic [2:0] f3, riscv_pkg::reg_addr_t rs2, rs1,
                                               logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], riscv_pkg::op_store};
    endfunction

    function automatic riscv_pkg::word_t enc_b(logic [2:0] f3, riscv_pkg::reg_addr_t rs1, rs2,
                                               riscv_pkg::word_t off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], riscv_pkg::op_branch};
    endfunction

    function automatic riscv_pkg::word_t enc_u(logic [6:0] op, riscv_pkg::reg_addr_t rd,
                                               logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic riscv_pkg::word_t enc_j(riscv_pkg::reg_addr_t rd, riscv_pkg::word_t off);
        return {off[20], off[10:1], off[11], off[19:12], rd, riscv_pkg::op_jal};
    endfunction

    function automatic riscv_pkg::word_t csrw(riscv_pkg::reg_addr_t rs);
        return enc_i(riscv_pkg::op_system, 3'b001, 5'd0, rs, riscv_pkg::csr_tohost);
    endfunction

    // RV32I integer semantics, alt selects sub and sra
    function automatic riscv_pkg::word_t rv_arith(logic [2:0] f3, logic alt,
                                                  riscv_pkg::word_t a, riscv_pkg::word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, riscv_pkg::word_t a, riscv_pkg::word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic emit(riscv_pkg::word_t inst);
        prog.push_back(inst);
    endtask

    task automatic expect_tohost(riscv_pkg::reg_addr_t rs, riscv_pkg::word_t value);
        emit(csrw(rs));
        expv.push_back(value);
    endtask

    task automatic li(riscv_pkg::reg_addr_t rd, riscv_pkg::word_t v);
        riscv_pkg::word_t up;
        up = v + 32'h800;
        emit(enc_u(riscv_pkg::op_lui, rd, up[31:12]));
        emit(enc_i(riscv_pkg::op_imm, 3'b000, rd, rd, v[11:0]));
    endtask

    task automatic check_word(string name, riscv_pkg::word_t expected, riscv_pkg::word_t actual);
        if (actual !== expected) begin
            $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        if (actual != expected) begin
            $display("** Error [%s]: expected %0d tohost writes, actual %0d",
                     name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic begin_test();
        prog.delete();
        expv.delete();
        test_errors = 0;
    endtask

    // Program ends in a jal-to-self so nothing runs past it
    task automatic load_program();
        emit(enc_j(5'd0, 32'd0));
        rst = 1'b1;
        foreach (prog[i]) begin
            prog_we = 1'b1;
            prog_addr = i;
            prog_data = prog[i];
            step();
        end
        prog_we = 1'b0;
        repeat (5) step();
        rst = 1'b0;
    endtask

    task automatic collect(string name, int n);
        int idle;
        idle = 0;
        got.delete();
        // Keep listening after the last expected write to catch extras
        while (idle < ((got.size() < n) ? 200 : 20)) begin
            step();
            if (tohost_valid) begin
                got.push_back(tohost);
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got.size() < n) begin
            $display("Timeout in %s: no tohost write for 200 cycles after %0d of %0d",
                     name, got.size(), n);
            test_errors++;
        end
    endtask

    task automatic compare_results(string name);
        check_count(name, expv.size(), got.size());
        for (int i = 0; i < expv.size() && i < got.size(); i++) begin
            check_word(name, expv[i], got[i]);
        end
    endtask

    task automatic end_test(string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            failed_tests++;
        end
        total_errors += test_errors;
    endtask

    task automatic run_and_check(string name);
        load_program();
        collect(name, expv.size());
        compare_results(name);
        end_test(name);
    endtask

    task automatic test_alu();
        riscv_pkg::word_t ra, rb, a, b, u, pc;
        logic [11:0] imm;
        begin_test();
        for (int f = 0; f < 8; f++) begin
            ra = xorshift();
            rb = xorshift();
            a = sext12(ra[11:0]);
            b = sext12(rb[11:0]);
            emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd1, 5'd0, ra[11:0]));
            emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd2, 5'd0, rb[11:0]));
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 1 && f != 0 && f != 5) continue;
                emit(enc_r(alt ? 7'h20 : 7'h00, f[2:0], 5'd3, 5'd1, 5'd2));
                expect_tohost(5'd3, rv_arith(f[2:0], alt[0], a, b));
                if (alt == 0 || f == 5) begin
                    imm = (f == 1 || f == 5) ? {(alt ? 7'h20 : 7'h00), rb[16:12]} : rb[23:12];
                    emit(enc_i(riscv_pkg::op_imm, f[2:0], 5'd4, 5'd1, imm));
                    expect_tohost(5'd4, rv_arith(f[2:0], alt[0], a, sext12(imm)));
                end
            end
        end
        u = xorshift();
        emit(enc_u(riscv_pkg::op_lui, 5'd7, u[19:0]));
        expect_tohost(5'd7, {u[19:0], 12'b0});
        pc = prog.size() * 4;
        emit(enc_u(riscv_pkg::op_auipc, 5'd8, u[31:12]));
        expect_tohost(5'd8, pc + {u[31:12], 12'b0});
        run_and_check("alu_ops");
    endtask

    task automatic test_forwarding();
        riscv_pkg::word_t r, v1, v2, v3, v4, v6;
        begin_test();
        r = xorshift();
        v1 = sext12(r[11:0]);
        v2 = v1 + v1;
        v3 = v2 - v1;
        v4 = v3 ^ v2;
        v6 = v4 + 1;
        emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd1, 5'd0, r[11:0]));
        emit(enc_r(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
        emit(enc_r(7'h20, 3'b000, 5'd3, 5'd2, 5'd1));
        emit(enc_r(7'h00, 3'b100, 5'd4, 5'd3, 5'd2));
        emit(enc_s(3'b010, 5'd4, 5'd0, 12'd16));
        emit(enc_i(riscv_pkg::op_load, 3'b010, 5'd5, 5'd0, 12'd16));
        // Load result used by the very next instruction
        emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd6, 5'd5, 12'd1));
        emit(enc_r(7'h00, 3'b000, 5'd7, 5'd6, 5'd5));
        emit(enc_i(riscv_pkg::op_load, 3'b010, 5'd8, 5'd0, 12'd16));
        expect_tohost(5'd8, v4);
        expect_tohost(5'd2, v2);
        expect_tohost(5'd3, v3);
        expect_tohost(5'd4, v4);
        expect_tohost(5'd6, v6);
        expect_tohost(5'd7, v6 + v4);
        run_and_check("forwarding");
    endtask

    task automatic test_branches();
        riscv_pkg::word_t a, b, p, q;
        int id;
        begin_test();
        id = 0;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) continue;
            a = xorshift();
            b = xorshift();
            // Pairs (a,b), (b,a) and (a,a) give both outcomes for every condition
            for (int k = 0; k < 3; k++) begin
                p = (k == 1) ? b : a;
                q = (k == 0) ? b : a;
                li(5'd1, p);
                li(5'd2, q);
                emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd9, 5'd0, 12'h100 + id));
                emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd10, 5'd0, 12'h200 + id));
                emit(enc_b(f[2:0], 5'd1, 5'd2, 32'd8));
                emit(csrw(5'd9));
                if (!branch_ref(f[2:0], p, q)) begin
                    expv.push_back(32'h100 + id);
                end
                expect_tohost(5'd10, 32'h200 + id);
                id++;
            end
        end
        run_and_check("branches");
    endtask

    task automatic test_jumps();
        riscv_pkg::word_t p, q, base;
        begin_test();
        emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd9, 5'd0, 12'h7ff));
        p = prog.size() * 4;
        emit(enc_j(5'd1, 32'd12));
        emit(csrw(5'd9));
        emit(csrw(5'd9));
        expect_tohost(5'd1, p + 4);
        // jalr lands on an odd sum, bit 0 must be cleared
        q = prog.size() * 4 + 4;
        base = q + 16 - 4;
        emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd2, 5'd0, base[11:0]));
        emit(enc_i(riscv_pkg::op_jalr, 3'b000, 5'd5, 5'd2, 12'd5));
        repeat (3) emit(csrw(5'd9));
        expect_tohost(5'd5, q + 4);
        run_and_check("jumps");
    endtask

    task automatic store_op(logic [2:0] f3, int off);
        riscv_pkg::word_t v;
        v = xorshift();
        li(5'd2, v);
        emit(enc_s(f3, 5'd2, 5'd1, off[11:0]));
        dmodel[off] = v[7:0];
        if (f3 != 3'b000) begin
            dmodel[off + 1] = v[15:8];
        end
        if (f3 == 3'b010) begin
            dmodel[off + 2] = v[23:16];
            dmodel[off + 3] = v[31:24];
        end
    endtask

    task automatic load_op(logic [2:0] f3, int off);
        riscv_pkg::word_t e;
        logic [15:0] h;
        h = {dmodel[off + 1], dmodel[off]};
        case (f3)
            3'b000: e = {{24{h[7]}}, h[7:0]};
            3'b100: e = {24'b0, h[7:0]};
            3'b001: e = {{16{h[15]}}, h};
            3'b101: e = {16'b0, h};
            default: e = {dmodel[off + 3], dmodel[off + 2], h};
        endcase
        emit(enc_i(riscv_pkg::op_load, f3, 5'd6, 5'd1, off[11:0]));
        expect_tohost(5'd6, e);
    endtask

    task automatic test_loads_stores();
        begin_test();
        emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd1, 5'd0, 12'd64));
        store_op(3'b010, 0);
        store_op(3'b010, 4);
        store_op(3'b000, 1);
        store_op(3'b000, 7);
        store_op(3'b001, 2);
        store_op(3'b001, 4);
        for (int off = 0; off < 8; off++) begin
            load_op(3'b000, off);
            load_op(3'b100, off);
        end
        for (int off = 0; off < 8; off += 2) begin
            load_op(3'b001, off);
            load_op(3'b101, off);
        end
        load_op(3'b010, 0);
        load_op(3'b010, 4);
        run_and_check("load_store");
    endtask

    task automatic test_reset();
        begin_test();
        emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd1, 5'd0, 12'h123));
        expect_tohost(5'd1, 32'h123);
        load_program();
        collect("reset", 1);
        compare_results("reset");
        // Second program loaded while the first one spins
        prog.delete();
        expv.delete();
        repeat (4) emit(riscv_pkg::nop_inst);
        emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd1, 5'd0, 12'h456));
        expect_tohost(5'd1, 32'h456);
        emit(enc_i(riscv_pkg::op_imm, 3'b000, 5'd1, 5'd1, 12'd1));
        expect_tohost(5'd1, 32'h457);
        load_program();
        check_word("reset", 32'h0, tohost);
        check_word("reset", 32'h0, {31'b0, tohost_valid});
        collect("reset", 2);
        compare_results("reset");
        end_test("reset");
    endtask

    initial begin
        rst = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        test_alu();
        test_forwarding();
        test_branches();
        test_jumps();
        test_loads_stores();
        test_reset();
        $display("tests run: 6, failed: %0d, errors: %0d", failed_tests, total_errors);
        if (failed_tests == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
riscv_pkg.sv
dmem_if.sv
reg_file.sv
imm_gen.sv
alu.sv
decoder.sv
mem_align.sv
imem.sv
dmem.sv
cpu.sv
tb_cpu.sv
